/* list.f */
verilog/fixed_pkg.sv
verilog/voicing_pkg.sv
verilog/band_energy_acc.sv
verilog/voicing_ctrl.sv
verilog/voicing_decision.sv
verilog/voicing_estimator.sv
verif/voicing_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the voicing bench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module voicing_tb -Mdir obj_dir -o voicing_sim -f list.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/voicing_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Regression failed" "$LOG"; then
	exit 1
fi
exit 0

/* verif/voicing_tb.sv */
// Bench for the voicing stage with a 3-cycle amplitude memory that answers every read.
// Expected energies and flag come from a reference model of the band and decision rules.
// The run is bounded by a cycle limit sized for 40 frames of up to 80 harmonics.
`timescale 1ns/10ps

module voicing_tb;

	import fixed_pkg::*;
	import voicing_pkg::*;

	localparam int AM_READ_LATENCY = 3;
	localparam int NUM_RANDOM = 20;
	localparam int RESET_CYCLES = 10;
	localparam int TIMEOUT_CYCLES = 40 * (2 * 80 + 20) + RESET_CYCLES;
	localparam fix_t AMP_ONE = 32'h0001_0000;
	localparam fix_t AMP_HALF = 32'h0000_8000;
	localparam fix_t AMP_TENTH = 32'h0000_1999;
	localparam fix_t WO_TYPICAL = 32'h0000_2000;    // Well above the low-pitch limit

	logic          clk;
	logic          rst;
	logic          start;
	frame_params_t frame;
	harm_idx_t     am_addr;
	fix_t          am_data;
	logic          voiced;
	band_energy_t  energies;
	logic          done;

	fix_t amp_mem [1024];
	fix_t [AM_READ_LATENCY-1:0] rd_pipe = '0;
	logic [(AM_READ_LATENCY+1)*32-1:0] rd_shift;
	logic [31:0] rng = 32'h74fcd3cd;
	logic idle_check = 1'b1;    // Until the first start
	fix_t exp_elow = '0;
	fix_t exp_ehigh = '0;
	logic exp_voiced = 1'b0;
	int   assert_errors = 0;
	int   check_errors = 0;
	int   done_count = 0;
	int   tests_run = 0;
	int   tests_failed = 0;
	int   cycle_count = 0;

	voicing_estimator #(
		.AM_READ_LATENCY (AM_READ_LATENCY)
	) DUT (
		.clk      (clk),
		.rst      (rst),
		.start    (start),
		.frame    (frame),
		.am_addr  (am_addr),
		.am_data  (am_data),
		.voiced   (voiced),
		.energies (energies),
		.done     (done)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//----------------------------------------------------------------------
	// Amplitude memory, data AM_READ_LATENCY cycles after the address
	//----------------------------------------------------------------------

	assign rd_shift = {rd_pipe, amp_mem[am_addr]};
	assign am_data = rd_pipe[AM_READ_LATENCY-1];

	always @(posedge clk)
		rd_pipe <= rd_shift[AM_READ_LATENCY*32-1:0];

	always @(negedge clk)
	begin
		if (done)
			done_count <= done_count + 1;
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout after %0d cycles, the run did not complete", cycle_count);
			$display("Regression failed");
			$finish;
		end
	end

	//----------------------------------------------------------------------
	// Reference model
	//----------------------------------------------------------------------

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic fix_t square_sat(input fix_t a);
		longint unsigned p;
		p = (64'(a) * 64'(a)) >> FRAC_BITS;
		if (p > 64'(FIX_MAX))
			return FIX_MAX;
		return fix_t'(p);
	endfunction

	function automatic fix_t add_sat(input fix_t a, input fix_t b);
		longint unsigned s;
		s = 64'(a) + 64'(b);
		return (s > 64'(FIX_MAX)) ? FIX_MAX : fix_t'(s);
	endfunction

	// Inclusive range, empty when hi < lo
	function automatic fix_t band_sum(input int lo, input int hi);
		fix_t s;
		s = ENERGY_FLOOR;
		for (int i = lo; i <= hi; i++)
			s = add_sat(s, square_sat(amp_mem[harm_idx_t'(i)]));
		return s;
	endfunction

	function automatic logic ref_voiced(input fix_t elow, input fix_t ehigh, input fix_t wo,
		input logic snr);
		longint unsigned lo;
		longint unsigned hi;
		logic v;
		lo = 64'(elow);
		hi = 64'(ehigh);
		v = snr;
		if (!snr && lo > hi * 64'(RATIO_HI_GAIN))
			v = 1'b1;
		if (snr && lo * 64'(RATIO_HI_GAIN) < hi)
			v = 1'b0;
		// Low pitch can only clear
		if (lo * 64'd65536 < hi * 64'(RATIO_LOW_GAIN) && wo <= WO_LOW_PITCH)
			v = 1'b0;
		return v;
	endfunction

	function automatic frame_params_t make_frame(input int n, input fix_t wo, input logic snr);
		frame_params_t f;
		f.num_harm = harm_idx_t'(n);
		f.wo = wo;
		f.snr_voiced = snr;
		return f;
	endfunction

	function automatic int error_total();
		return assert_errors + check_errors;
	endfunction

	//----------------------------------------------------------------------
	// Stimulus
	//----------------------------------------------------------------------

	task automatic fill_random(input fix_t mask, input fix_t set_bits);
		for (int i = 0; i < 1024; i++)
		begin
			rng = xorshift32(rng);
			amp_mem[harm_idx_t'(i)] = (rng & mask) | set_bits;
		end
	endtask

	// Shared 2 kHz entry is zeroed so each band sees only its own amplitude
	task automatic fill_bands(input fix_t low_amp, input fix_t high_amp, input int n);
		int q;
		q = n / 4;
		fill_random(32'h000F_FFFF, '0);
		for (int i = 1; i < 2 * q; i++)
			amp_mem[harm_idx_t'(i)] = low_amp;
		amp_mem[harm_idx_t'(2 * q)] = '0;
		for (int i = 2 * q + 1; i <= 4 * q; i++)
			amp_mem[harm_idx_t'(i)] = high_amp;
	endtask

	task automatic set_expected(input frame_params_t f);
		int q;
		q = int'(f.num_harm) / 4;
		exp_elow = band_sum(1, 2 * q);
		exp_ehigh = band_sum(2 * q, 4 * q);
		exp_voiced = ref_voiced(exp_elow, exp_ehigh, f.wo, f.snr_voiced);
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run = tests_run + 1;
		if (error_total() == errors_before)
			$display("%s ok", name);
		else
		begin
			tests_failed = tests_failed + 1;
			$display("%s FAILED", name);
		end
	endtask

	task automatic run_frame(input string name, input frame_params_t f, input logic busy_start,
		input int want);
		int errors_before;
		int dones_before;
		errors_before = error_total();
		dones_before = done_count;
		set_expected(f);
		if (want >= 0 && exp_voiced != want[0])
		begin
			$display("Stimulus of %s does not reach its voicing rule", name);
			check_errors = check_errors + 1;
		end
		@(posedge clk);
		frame <= f;
		start <= 1'b1;
		idle_check <= 1'b0;
		@(posedge clk);
		start <= 1'b0;
		if (busy_start)
		begin
			repeat (3) @(posedge clk);
			start <= 1'b1;
			@(posedge clk);
			start <= 1'b0;
		end
		@(negedge clk);
		while (!done)
			@(negedge clk);
		repeat (4) @(negedge clk);    // Stray done pulses would show up here
		assert (done_count == dones_before + 1)
		else
		begin
			$display("%s gave %0d done pulses instead of one", name, done_count - dones_before);
			check_errors = check_errors + 1;
		end
		finish_test(name, errors_before);
	endtask

	initial
	begin
		rst = 1'b0;
		start = 1'b0;
		frame = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b1;
		repeat (5) @(negedge clk);
		finish_test("reset_state", 0);

		for (int i = 0; i < NUM_RANDOM; i++)
		begin
			fill_random(32'h000F_FFFF, '0);
			rng = xorshift32(rng);
			run_frame($sformatf("random_%0d", i),
				make_frame(4 + int'(rng % 32'd77), rng & 32'h0000_1FFF, rng[20]), 1'b0, -1);
		end

		fill_random(32'h0000_FFFF, 32'hFFFF_0000);
		run_frame("saturate_square", make_frame(80, WO_TYPICAL, 1'b1), 1'b0, -1);
		fill_random(32'h003F_FFFF, 32'h00C0_0000);
		run_frame("saturate_sum", make_frame(64, 32'h0000_0800, 1'b0), 1'b0, -1);

		fill_bands(AMP_ONE, AMP_TENTH, 40);
		run_frame("low_dominant", make_frame(40, WO_TYPICAL, 1'b0), 1'b0, 1);
		fill_bands(AMP_ONE, AMP_ONE, 40);
		run_frame("balanced_unvoiced", make_frame(40, WO_TYPICAL, 1'b0), 1'b0, 0);
		fill_bands(AMP_TENTH, AMP_ONE, 40);
		run_frame("high_dominant", make_frame(40, WO_TYPICAL, 1'b1), 1'b0, 0);
		fill_bands(AMP_ONE, AMP_ONE, 40);
		run_frame("balanced_voiced", make_frame(40, WO_TYPICAL, 1'b1), 1'b0, 1);

		// Ratio near -6 dB, between the two thresholds
		fill_bands(AMP_HALF, AMP_ONE, 40);
		run_frame("low_pitch_at_limit", make_frame(40, WO_LOW_PITCH, 1'b1), 1'b0, 0);
		run_frame("low_pitch_below", make_frame(40, 32'h0000_0800, 1'b1), 1'b0, 0);
		run_frame("low_pitch_above", make_frame(40, WO_LOW_PITCH + 32'd1, 1'b1), 1'b0, 1);

		fill_random(32'h000F_FFFF, '0);
		run_frame("empty_low_band", make_frame(3, WO_TYPICAL, 1'b1), 1'b0, -1);
		fill_random(32'h000F_FFFF, '0);
		run_frame("start_while_busy", make_frame(40, WO_TYPICAL, 1'b0), 1'b1, -1);

		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, error_total());
		if (tests_failed == 0 && error_total() == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	//----------------------------------------------------------------------
	// Checks
	//----------------------------------------------------------------------

	a_idle_done: assert property (@(posedge clk) disable iff (!rst) idle_check |-> !done)
		else
		begin
			$display("done pulsed before any start");
			assert_errors = assert_errors + 1;
		end

	a_idle_voiced: assert property (@(posedge clk) disable iff (!rst)
		idle_check |-> voiced == 1'b0)
		else
		begin
			$display("** Error: voiced expected 0, actual %h", voiced);
			assert_errors = assert_errors + 1;
		end

	a_idle_energies: assert property (@(posedge clk) disable iff (!rst)
		idle_check |-> energies == '0)
		else
		begin
			$display("** Error: energies expected %h, actual %h", 64'h0, energies);
			assert_errors = assert_errors + 1;
		end

	a_idle_addr: assert property (@(posedge clk) disable iff (!rst)
		idle_check |-> am_addr == '0)
		else
		begin
			$display("** Error: am_addr expected %h, actual %h", 10'h0, am_addr);
			assert_errors = assert_errors + 1;
		end

	a_elow: assert property (@(posedge clk) disable iff (!rst)
		done |-> energies.elow == exp_elow)
		else
		begin
			$display("** Error: energies.elow expected %h, actual %h", exp_elow, energies.elow);
			assert_errors = assert_errors + 1;
		end

	a_ehigh: assert property (@(posedge clk) disable iff (!rst)
		done |-> energies.ehigh == exp_ehigh)
		else
		begin
			$display("** Error: energies.ehigh expected %h, actual %h", exp_ehigh,
				energies.ehigh);
			assert_errors = assert_errors + 1;
		end

	a_voiced: assert property (@(posedge clk) disable iff (!rst) done |-> voiced == exp_voiced)
		else
		begin
			$display("** Error: voiced expected %h, actual %h", exp_voiced, voiced);
			assert_errors = assert_errors + 1;
		end

	a_done_single: assert property (@(posedge clk) disable iff (!rst) done |=> !done)
		else
		begin
			$display("done stayed high for more than one cycle");
			assert_errors = assert_errors + 1;
		end

endmodule

/* verilog/voicing_estimator.sv */
// Band-energy voicing stage, one frame per start pulse.
// frame must be held from start until done. The amplitude memory answers
// every read after AM_READ_LATENCY cycles (1 to 4) and has no stall.
`timescale 1ns/10ps

module voicing_estimator #(
	parameter int AM_READ_LATENCY = 2
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       start,
	input  voicing_pkg::frame_params_t frame,
	output fixed_pkg::harm_idx_t       am_addr,
	input  fixed_pkg::fix_t            am_data,
	output logic                       voiced,
	output voicing_pkg::band_energy_t  energies,
	output logic                       done
);

	import fixed_pkg::*;
	import voicing_pkg::*;

	logic      acc_start;
	logic      acc_done;
	logic      decide;
	harm_idx_t acc_first;
	harm_idx_t acc_last;
	fix_t      acc_sum;

	voicing_ctrl u_ctrl (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.num_harm  (frame.num_harm),
		.acc_start (acc_start),
		.first     (acc_first),
		.last      (acc_last),
		.acc_done  (acc_done),
		.sum       (acc_sum),
		.energies  (energies),
		.decide    (decide),
		.done      (done)
	);

	band_energy_acc #(
		.AM_READ_LATENCY (AM_READ_LATENCY)
	) u_acc (
		.clk       (clk),
		.rst       (rst),
		.acc_start (acc_start),
		.first     (acc_first),
		.last      (acc_last),
		.am_addr   (am_addr),
		.am_data   (am_data),
		.acc_done  (acc_done),
		.sum       (acc_sum)
	);

	voicing_decision u_decision (
		.clk        (clk),
		.rst        (rst),
		.decide     (decide),
		.energies   (energies),
		.wo         (frame.wo),
		.snr_voiced (frame.snr_voiced),
		.voiced     (voiced)
	);

	// Memory is only read while a band sum runs
	a_reads_in_band: assert property (@(posedge clk) disable iff (!rst)
		u_acc.rd_active |-> u_ctrl.state inside {ST_LOW, ST_HIGH})
		else $error("amplitude read outside a band sum");

	a_voiced_at_done: assert property (@(posedge clk) disable iff (!rst)
		$changed(voiced) |-> done)
		else $error("voiced changed without done");

endmodule

/* verilog/voicing_decision.sv */
// Energy-ratio and low-pitch voicing rules. The low-pitch rule can only clear
// the flag. Products are full width, so no comparison can overflow.
`timescale 1ns/10ps

module voicing_decision (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      decide,
	input  voicing_pkg::band_energy_t energies,
	input  fixed_pkg::fix_t           wo,
	input  logic                      snr_voiced,
	output logic                      voiced
);

	import fixed_pkg::*;
	import voicing_pkg::*;

	logic [35:0] elow_x10;
	logic [35:0] ehigh_x10;
	logic [63:0] elow_q16;
	logic [63:0] ehigh_xg;
	logic        ratio_voiced;
	logic        low_pitch;
	logic        next_voiced;

	assign elow_x10 = {4'd0, energies.elow} * 36'(RATIO_HI_GAIN);
	assign ehigh_x10 = {4'd0, energies.ehigh} * 36'(RATIO_HI_GAIN);

	// elow/ehigh < 10^-0.4 without a divide
	assign elow_q16 = 64'(energies.elow) << FRAC_BITS;
	assign ehigh_xg = {32'd0, energies.ehigh} * {32'd0, RATIO_LOW_GAIN};

	always_comb
	begin
		if (snr_voiced)
			ratio_voiced = !(elow_x10 < {4'd0, energies.ehigh});    // Below -10 dB
		else
			ratio_voiced = {4'd0, energies.elow} > ehigh_x10;       // Above +10 dB
		low_pitch = (elow_q16 < ehigh_xg) && (wo <= WO_LOW_PITCH);
		next_voiced = ratio_voiced && !low_pitch;
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			voiced <= 1'b0;
		else if (decide)
			voiced <= next_voiced;
	end

endmodule

/* verilog/voicing_ctrl.sv */
// Runs the low band (1..2 kHz index) and then the high band (2 kHz..4 kHz index)
// through the accumulator and triggers the decision. num_harm must stay
// stable from start until done. A start outside idle is dropped.
`timescale 1ns/10ps

module voicing_ctrl (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     start,
	input  fixed_pkg::harm_idx_t     num_harm,
	output logic                     acc_start,
	output fixed_pkg::harm_idx_t     first,
	output fixed_pkg::harm_idx_t     last,
	input  logic                     acc_done,
	input  fixed_pkg::fix_t          sum,
	output voicing_pkg::band_energy_t energies,
	output logic                     decide,
	output logic                     done
);

	import fixed_pkg::*;
	import voicing_pkg::*;

	ctrl_state_t state;
	harm_idx_t   lim_1k;
	harm_idx_t   lim_2k;
	harm_idx_t   lim_4k;
	harm_idx_t   high_last;    // Upper limit of the second band

	assign lim_1k = num_harm >> 2;
	assign lim_2k = lim_1k << 1;
	assign lim_4k = lim_1k << 2;

	assign decide = (state == ST_DECIDE);
	assign done = (state == ST_FINISH);    // Voiced is valid from this cycle

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= ST_IDLE;
			acc_start <= 1'b0;
			energies <= '0;
		end
		else
		begin
			acc_start <= 1'b0;
			case (state)
				ST_IDLE:
				begin
					if (start)
					begin
						acc_start <= 1'b1;
						state <= ST_LOW;
					end
				end
				ST_LOW:
				begin
					if (acc_done)
					begin
						energies.elow <= sum;
						acc_start <= 1'b1;
						state <= ST_HIGH;
					end
				end
				ST_HIGH:
				begin
					if (acc_done)
					begin
						energies.ehigh <= sum;
						state <= ST_DECIDE;
					end
				end
				ST_DECIDE: state <= ST_FINISH;
				ST_FINISH: state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Band limits, held for the accumulator while it runs
	always_ff @(posedge clk)
	begin
		if (state == ST_IDLE && start)
		begin
			first <= harm_idx_t'(1);
			last <= lim_2k;
			high_last <= lim_4k;
		end
		else if (state == ST_LOW && acc_done)
		begin
			first <= last;    // High band starts at the 2 kHz index
			last <= high_last;
		end
	end

	a_start_idle: assert property (@(posedge clk) disable iff (!rst)
		start |-> state == ST_IDLE)
		else $warning("start while busy, ignored");

	a_done_in_band: assert property (@(posedge clk) disable iff (!rst)
		acc_done |-> state inside {ST_LOW, ST_HIGH})
		else $error("acc_done outside a band sum");

endmodule

/* verilog/band_energy_acc.sv */
// Sums squared amplitudes over first..last, both inclusive, one read per cycle.
// The memory must return data exactly AM_READ_LATENCY cycles after the address
// (1 to 4). first and last must be held stable until acc_done.
`timescale 1ns/10ps

module band_energy_acc #(
	parameter int AM_READ_LATENCY = 2
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                acc_start,
	input  fixed_pkg::harm_idx_t first,
	input  fixed_pkg::harm_idx_t last,
	output fixed_pkg::harm_idx_t am_addr,
	input  fixed_pkg::fix_t     am_data,
	output logic                acc_done,
	output fixed_pkg::fix_t     sum
);

	import fixed_pkg::*;

	// Tag travelling alongside each read
	typedef struct packed {
		logic vld;
		logic tail;    // Last index of the range
	} rd_tag_t;

	harm_idx_t addr_q;
	logic      rd_active;
	logic      range_empty;
	rd_tag_t [AM_READ_LATENCY-1:0] pipe;
	rd_tag_t   sq_tag;
	fix_t      sq_q;
	fix_t      acc;

	// Q32.32 square cut back to Q16.16
	function automatic fix_t sat_square(input fix_t a);
		logic [63:0] p;
		p = {32'd0, a} * {32'd0, a};
		if (p[63:48] != 16'd0)
			return FIX_MAX;
		return p[47:16];
	endfunction

	function automatic fix_t sat_add(input fix_t a, input fix_t b);
		logic [32:0] s;
		s = {1'b0, a} + {1'b0, b};
		return s[32] ? FIX_MAX : s[31:0];
	endfunction

	assign range_empty = last < first;
	assign am_addr = addr_q;
	assign sum = acc;

	//----------------------------------------------------------------------
	// Address counter
	//----------------------------------------------------------------------

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			addr_q <= '0;
			rd_active <= 1'b0;
		end
		else if (acc_start && !range_empty)
		begin
			addr_q <= first;
			rd_active <= 1'b1;
		end
		else if (rd_active)
		begin
			if (addr_q == last)
				rd_active <= 1'b0;
			else
				addr_q <= addr_q + 1'b1;
		end
	end

	// Reads in flight, aligned with am_data at the far end
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			pipe <= '0;
			sq_tag <= '0;
			acc_done <= 1'b0;
		end
		else
		begin
			pipe[0].vld <= rd_active;
			pipe[0].tail <= rd_active && (addr_q == last);
			for (int i = 1; i < AM_READ_LATENCY; i++)
				pipe[i] <= pipe[i-1];
			sq_tag <= pipe[AM_READ_LATENCY-1];
			acc_done <= (acc_start && range_empty) || (sq_tag.vld && sq_tag.tail);
		end
	end

	//----------------------------------------------------------------------
	// Square and accumulate
	//----------------------------------------------------------------------

	always_ff @(posedge clk)
	begin
		sq_q <= sat_square(am_data);
		if (acc_start)
			acc <= ENERGY_FLOOR;
		else if (sq_tag.vld)
			acc <= sat_add(acc, sq_q);
	end

	a_done_after_reads: assert property (@(posedge clk) disable iff (!rst)
		acc_done |-> !rd_active)
		else $error("acc_done raised while reads are still being issued");

endmodule

/* verilog/voicing_pkg.sv */
// Frame parameters, band energies and thresholds of the voicing decision.
// The ratio thresholds are applied as scaled products, so the ratio itself
// is never formed and no divider or log unit is needed.

package voicing_pkg;

	import fixed_pkg::*;

	typedef struct packed {
		harm_idx_t num_harm;    // Number of harmonics in the frame
		fix_t      wo;          // Fundamental, radians per sample
		logic      snr_voiced;  // Preliminary flag from the SNR stage
	} frame_params_t;

	typedef struct packed {
		fix_t elow;
		fix_t ehigh;
	} band_energy_t;

	//----------------------------------------------------------------------
	// Decision thresholds
	//----------------------------------------------------------------------

	localparam int unsigned RATIO_HI_GAIN = 10;   // +/-10 dB
	localparam fix_t RATIO_LOW_GAIN = 32'h0000_65EA;  // 10^-0.4, i.e. -4 dB
	localparam fix_t WO_LOW_PITCH = 32'h0000_0C10;    // About 60 Hz

	// Frame sequencer
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOW,
		ST_HIGH,
		ST_DECIDE,
		ST_FINISH
	} ctrl_state_t;

endpackage

/* verilog/fixed_pkg.sv */
// Unsigned Q16.16 magnitudes only. Every quantity in the voicing stage is
// non-negative, so there is no sign bit and all arithmetic saturates at FIX_MAX.
// Harmonic indices are 10 bits, enough for the 4 kHz band limit.

package fixed_pkg;

	//----------------------------------------------------------------------
	// Fixed-point word
	//----------------------------------------------------------------------

	localparam int FRAC_BITS = 16;

	typedef logic [31:0] fix_t;

	localparam fix_t FIX_MAX = '1;    // Saturation value

	// Small bias so that an empty band never reads as zero energy
	localparam fix_t ENERGY_FLOOR = 32'h0000_0006;

	//----------------------------------------------------------------------
	// Harmonic index
	//----------------------------------------------------------------------

	typedef logic [9:0] harm_idx_t;

endpackage
